/* rtl/muldiv_pkg.sv */
`default_nettype none

package muldiv_pkg;

    // Operand and result width.
    localparam int unsigned word_size = 32;

    // Bit counter width in both cores, counts 0 to 31.
    localparam int unsigned count_width = 5;

    // Operations accepted by the unit.
    typedef enum logic [2:0] {
        op_mul,
        op_mulh,
        op_mulhu,
        op_div,
        op_divu,
        op_rem,
        op_remu
    } muldiv_op_e;

    // Request from the requester, held stable while req is high.
    typedef struct packed {
        muldiv_op_e             op;
        logic [word_size-1:0]   a;
        logic [word_size-1:0]   b;
    } muldiv_req_t;

    // Response, valid while ack is high.
    typedef struct packed {
        logic [word_size-1:0]   result;
        logic                   div_by_zero;
    } muldiv_rsp_t;

endpackage

`default_nettype wire

/* rtl/restoring_divider.sv */
`default_nettype none

module restoring_divider (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                start,
    input  logic [muldiv_pkg::word_size-1:0]    dividend,
    input  logic [muldiv_pkg::word_size-1:0]    divisor,
    output logic [muldiv_pkg::word_size-1:0]    quotient,
    output logic [muldiv_pkg::word_size-1:0]    remainder,
    output logic                                busy
);

    // Partial remainder, dividend/quotient shifter and divisor.
    logic [muldiv_pkg::word_size-1:0]   rem_high;
    logic [muldiv_pkg::word_size-1:0]   quo_low;
    logic [muldiv_pkg::word_size-1:0]   divisor_q;
    logic [muldiv_pkg::count_width-1:0] count;

    logic [muldiv_pkg::word_size-1:0]   shifted;
    logic [muldiv_pkg::word_size:0]     diff;
    logic [muldiv_pkg::word_size-1:0]   next_high;
    logic                               q_bit;

    // One trial subtraction per cycle.
    always_comb begin
        shifted = {rem_high[muldiv_pkg::word_size-2:0], quo_low[muldiv_pkg::word_size-1]};
        diff = {1'b0, shifted} - {1'b0, divisor_q};
        // Bit shifted out of the top means the real value exceeds the divisor.
        q_bit = rem_high[muldiv_pkg::word_size-1] || !diff[muldiv_pkg::word_size];
        next_high = q_bit ? diff[muldiv_pkg::word_size-1:0] : shifted;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            count <= '0;
        end else if (start && !busy) begin
            busy <= 1'b1;
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
            if (count == '1) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            rem_high <= '0;
            quo_low <= dividend;
            divisor_q <= divisor;
        end else if (busy) begin
            rem_high <= next_high;
            quo_low <= {quo_low[muldiv_pkg::word_size-2:0], q_bit};
        end
    end

    assign quotient = quo_low;
    assign remainder = rem_high;

    // The sequencer must never restart a running division.
    start_while_busy: assert property (@(posedge clk) disable iff (reset)
        start |-> !busy);

endmodule

`default_nettype wire

/* rtl/shift_add_multiplier.sv */
`default_nettype none

module shift_add_multiplier (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    start,
    input  logic [muldiv_pkg::word_size-1:0]        multiplicand,
    input  logic [muldiv_pkg::word_size-1:0]        multiplier,
    output logic [2*muldiv_pkg::word_size-1:0]      product,
    output logic                                    busy
);

    // High half accumulates, low half shifts the multiplier out.
    logic [2*muldiv_pkg::word_size-1:0] acc;
    logic [muldiv_pkg::word_size-1:0]   mcand;
    logic [muldiv_pkg::count_width-1:0] count;
    logic [muldiv_pkg::word_size:0]     sum;

    // Carry out of the add lands in the top bit after the shift.
    always_comb begin
        sum = {1'b0, acc[2*muldiv_pkg::word_size-1:muldiv_pkg::word_size]};
        if (acc[0]) begin
            sum = sum + {1'b0, mcand};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            count <= '0;
        end else if (start && !busy) begin
            busy <= 1'b1;
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
            if (count == '1) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            acc <= {{muldiv_pkg::word_size{1'b0}}, multiplier};
            mcand <= multiplicand;
        end else if (busy) begin
            acc <= {sum, acc[muldiv_pkg::word_size-1:1]};
        end
    end

    assign product = acc;

    // Fixed latency, which the sequencer relies on.
    busy_length: assert property (@(posedge clk) disable iff (reset)
        (start && !busy) |=> busy [*32] ##1 !busy);

endmodule

`default_nettype wire

/* rtl/operand_sign_adjust.sv */
`default_nettype none

module operand_sign_adjust (
    input  muldiv_pkg::muldiv_op_e                  op,
    input  logic [muldiv_pkg::word_size-1:0]        a,
    input  logic [muldiv_pkg::word_size-1:0]        b,
    output logic [muldiv_pkg::word_size-1:0]        a_mag,
    output logic [muldiv_pkg::word_size-1:0]        b_mag,
    input  logic [muldiv_pkg::word_size-1:0]        quotient,
    input  logic [muldiv_pkg::word_size-1:0]        remainder,
    input  logic [2*muldiv_pkg::word_size-1:0]      product,
    output logic [muldiv_pkg::word_size-1:0]        result
);

    logic                               signed_op;
    logic                               a_neg;
    logic                               b_neg;
    logic [muldiv_pkg::word_size-1:0]   quot_adj;
    logic [muldiv_pkg::word_size-1:0]   rem_adj;
    logic [2*muldiv_pkg::word_size-1:0] prod_adj;

    // The low word of mul is the same for signed and unsigned operands.
    assign signed_op = (op == muldiv_pkg::op_mulh) || (op == muldiv_pkg::op_div) ||
                       (op == muldiv_pkg::op_rem);
    assign a_neg = signed_op && a[muldiv_pkg::word_size-1];
    assign b_neg = signed_op && b[muldiv_pkg::word_size-1];

    assign a_mag = a_neg ? (~a + 1'b1) : a;
    assign b_mag = b_neg ? (~b + 1'b1) : b;

    // Quotient rounds toward zero, remainder follows the dividend.
    assign quot_adj = (a_neg ^ b_neg) ? (~quotient + 1'b1) : quotient;
    assign rem_adj = a_neg ? (~remainder + 1'b1) : remainder;
    assign prod_adj = (a_neg ^ b_neg) ? (~product + 1'b1) : product;

    always_comb begin
        case (op)
            muldiv_pkg::op_mul:   result = product[muldiv_pkg::word_size-1:0];
            muldiv_pkg::op_mulh:  result = prod_adj[2*muldiv_pkg::word_size-1:
                                                    muldiv_pkg::word_size];
            muldiv_pkg::op_mulhu: result = product[2*muldiv_pkg::word_size-1:
                                                   muldiv_pkg::word_size];
            muldiv_pkg::op_div:   result = quot_adj;
            muldiv_pkg::op_divu:  result = quotient;
            muldiv_pkg::op_rem:   result = rem_adj;
            muldiv_pkg::op_remu:  result = remainder;
            default:              result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/muldiv_sequencer.sv */
`default_nettype none

module muldiv_sequencer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                req,
    input  muldiv_pkg::muldiv_req_t             request,
    output logic                                ack,
    output muldiv_pkg::muldiv_rsp_t             response,
    output muldiv_pkg::muldiv_op_e              op,
    output logic [muldiv_pkg::word_size-1:0]    a,
    output logic [muldiv_pkg::word_size-1:0]    b,
    output logic                                div_start,
    output logic                                mul_start,
    input  logic                                div_busy,
    input  logic                                mul_busy,
    input  logic [muldiv_pkg::word_size-1:0]    adjusted
);

    typedef enum logic [2:0] {
        st_idle,
        st_launch,
        st_wait_core,
        st_respond,
        st_release
    } state_e;

    state_e                             state;
    muldiv_pkg::muldiv_req_t            captured;
    logic                               div_op;
    logic                               quot_op;
    logic                               bypass;
    logic [muldiv_pkg::word_size-1:0]   bypass_result;

    assign op = captured.op;
    assign a = captured.a;
    assign b = captured.b;

    assign div_op = (captured.op == muldiv_pkg::op_div) || (captured.op == muldiv_pkg::op_divu) ||
                    (captured.op == muldiv_pkg::op_rem) || (captured.op == muldiv_pkg::op_remu);
    assign quot_op = (captured.op == muldiv_pkg::op_div) ||
                     (captured.op == muldiv_pkg::op_divu);
    assign bypass = div_op && (captured.b == '0);

    // All ones for a quotient, the dividend for a remainder.
    assign bypass_result = quot_op ? '1 : captured.a;

    // One-cycle start pulse while in launch.
    assign div_start = (state == st_launch) && div_op && !bypass;
    assign mul_start = (state == st_launch) && !div_op;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            ack <= 1'b0;
            response <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        state <= st_launch;
                    end
                end
                st_launch: begin
                    if (bypass) begin
                        response.result <= bypass_result;
                        response.div_by_zero <= 1'b1;
                        ack <= 1'b1;
                        state <= st_respond;
                    end else begin
                        state <= st_wait_core;
                    end
                end
                st_wait_core: begin
                    // Busy is already up on the first cycle here.
                    if (!div_busy && !mul_busy) begin
                        response.result <= adjusted;
                        response.div_by_zero <= 1'b0;
                        ack <= 1'b1;
                        state <= st_respond;
                    end
                end
                st_respond: begin
                    if (!req) begin
                        ack <= 1'b0;
                        state <= st_release;
                    end
                end
                st_release: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Request register.
    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            captured <= request;
        end
    end

    ack_held: assert property (@(posedge clk) disable iff (reset)
        (ack && req) |=> ack);

    one_core_busy: assert property (@(posedge clk) disable iff (reset)
        !(div_busy && mul_busy));

endmodule

`default_nettype wire

/* rtl/muldiv_unit.sv */
`default_nettype none

module muldiv_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        req,
    input  muldiv_pkg::muldiv_req_t     request,
    output logic                        ack,
    output muldiv_pkg::muldiv_rsp_t     response
);

    muldiv_pkg::muldiv_op_e                 op;
    logic [muldiv_pkg::word_size-1:0]       a;
    logic [muldiv_pkg::word_size-1:0]       b;
    logic [muldiv_pkg::word_size-1:0]       a_mag;
    logic [muldiv_pkg::word_size-1:0]       b_mag;
    logic [muldiv_pkg::word_size-1:0]       quotient;
    logic [muldiv_pkg::word_size-1:0]       remainder;
    logic [2*muldiv_pkg::word_size-1:0]     product;
    logic [muldiv_pkg::word_size-1:0]       adjusted;
    logic                                   div_start;
    logic                                   mul_start;
    logic                                   div_busy;
    logic                                   mul_busy;

    muldiv_sequencer sequencer (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .request   (request),
        .ack       (ack),
        .response  (response),
        .op        (op),
        .a         (a),
        .b         (b),
        .div_start (div_start),
        .mul_start (mul_start),
        .div_busy  (div_busy),
        .mul_busy  (mul_busy),
        .adjusted  (adjusted)
    );

    // Both cores see the same magnitudes.
    operand_sign_adjust sign_adjust (
        .op        (op),
        .a         (a),
        .b         (b),
        .a_mag     (a_mag),
        .b_mag     (b_mag),
        .quotient  (quotient),
        .remainder (remainder),
        .product   (product),
        .result    (adjusted)
    );

    restoring_divider divider (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .dividend  (a_mag),
        .divisor   (b_mag),
        .quotient  (quotient),
        .remainder (remainder),
        .busy      (div_busy)
    );

    shift_add_multiplier multiplier (
        .clk          (clk),
        .reset        (reset),
        .start        (mul_start),
        .multiplicand (a_mag),
        .multiplier   (b_mag),
        .product      (product),
        .busy         (mul_busy)
    );

endmodule

`default_nettype wire

/* tests/tb_muldiv.sv */
`default_nettype none

module tb_muldiv;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_corner = 5;
    localparam int n_random = 20;
    // Transactions over tests 1 to 6 in order.
    localparam int num_transactions = 2 * n_corner * n_corner + 2 * n_random +
                                      n_corner * n_corner + n_random +
                                      10 + 2 * n_random + 2 * n_random + 12 + 3;
    localparam int cycle_limit = num_transactions * 50 + 200;

    logic                                   clk;
    logic                                   reset;
    logic                                   req;
    muldiv_pkg::muldiv_req_t                request;
    logic                                   ack;
    muldiv_pkg::muldiv_rsp_t                response;

    muldiv_pkg::muldiv_rsp_t                exp_rsp;
    logic [muldiv_pkg::word_size-1:0]       last_result;
    logic [muldiv_pkg::word_size-1:0]       last_quot;
    logic                                   pair_active;
    logic [31:0]                            rng_state;
    int                                     errors;
    int                                     tests_passed;
    int                                     tests_failed;
    int                                     cycles = 0;

    muldiv_unit dut (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .request  (request),
        .ack      (ack),
        .response (response)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] random_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [muldiv_pkg::word_size-1:0] corner(input int i);
        case (i)
            0: return 32'h0000_0000;
            1: return 32'h0000_0001;
            2: return 32'hffff_ffff;
            3: return 32'h8000_0000;
            default: return 32'h7fff_ffff;
        endcase
    endfunction

    function automatic logic [63:0] widen(input logic [31:0] x);
        return {32'h0, x};
    endfunction

    // Expected response worked out in 64 bits.
    function automatic muldiv_pkg::muldiv_rsp_t reference_model(
        input muldiv_pkg::muldiv_op_e op, input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] sval;
        logic [63:0]        uprod;
        muldiv_pkg::muldiv_rsp_t rsp;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        uprod = widen(a) * widen(b);
        rsp = '0;
        sval = '0;
        case (op)
            muldiv_pkg::op_mul:   rsp.result = uprod[31:0];
            muldiv_pkg::op_mulhu: rsp.result = uprod[63:32];
            muldiv_pkg::op_mulh: begin
                sval = sa * sb;
                rsp.result = sval[63:32];
            end
            default: begin
                rsp.div_by_zero = (b == 32'h0);
                if (b == 32'h0) begin
                    // Quotient of all ones and remainder equal to the dividend.
                    rsp.result = (op == muldiv_pkg::op_div || op == muldiv_pkg::op_divu) ?
                                 32'hffff_ffff : a;
                end else if (op == muldiv_pkg::op_div) begin
                    sval = sa / sb;
                    rsp.result = sval[31:0];
                end else if (op == muldiv_pkg::op_rem) begin
                    sval = sa % sb;
                    rsp.result = sval[31:0];
                end else if (op == muldiv_pkg::op_divu) begin
                    rsp.result = a / b;
                end else begin
                    rsp.result = a % b;
                end
            end
        endcase
        return rsp;
    endfunction

    // One four-phase transaction. Hold keeps req up for extra cycles.
    task automatic run_op(input muldiv_pkg::muldiv_op_e op, input logic [31:0] a,
                          input logic [31:0] b, input int hold);
        @(negedge clk);
        request.op = op;
        request.a = a;
        request.b = b;
        exp_rsp = reference_model(op, a, b);
        req = 1'b1;
        do @(negedge clk); while (!ack);
        last_result = response.result;
        repeat (hold) @(negedge clk);
        req = 1'b0;
        do @(negedge clk); while (ack);
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    result_check: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> response.result == exp_rsp.result)
    else begin
        errors++;
        $display("ERR %0t response.result expected %h actual %h",
                 $time, exp_rsp.result, response.result);
    end

    flag_check: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> response.div_by_zero == exp_rsp.div_by_zero)
    else begin
        errors++;
        $display("ERR %0t response.div_by_zero expected %b actual %b",
                 $time, exp_rsp.div_by_zero, response.div_by_zero);
    end

    // Unsigned division identity on the remu of a divu/remu pair.
    identity_check: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) && pair_active |->
            widen(last_quot) * widen(request.b) + widen(response.result) == widen(request.a)
            && response.result < request.b)
    else begin
        errors++;
        $display("Quotient and remainder of %h / %h do not rebuild the dividend at %0t",
                 request.a, request.b, $time);
    end

    hold_check: assert property (@(posedge clk) disable iff (reset)
        (ack && req) |=> ack && $stable(response))
    else begin
        errors++;
        $display("Ack or response changed while req was still high at %0t", $time);
    end

    release_check: assert property (@(posedge clk) disable iff (reset)
        (ack && !req) |=> !ack)
    else begin
        errors++;
        $display("Ack did not fall on the edge after req dropped at %0t", $time);
    end

    reset_check: assert property (@(posedge clk) $fell(reset) |-> !ack)
    else begin
        errors++;
        $display("ERR %0t ack expected 0 actual %b", $time, ack);
    end

    initial begin
        int start_errors;
        logic [31:0] x;
        logic [31:0] y;
        clk = 1'b0;
        reset = 1'b1;
        req = 1'b0;
        request = '0;
        exp_rsp = '0;
        last_result = '0;
        last_quot = '0;
        pair_active = 1'b0;
        rng_state = 32'hdd39_b99d;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        start_errors = errors;
        for (int i = 0; i < n_corner; i++) begin
            for (int j = 0; j < n_corner; j++) begin
                run_op(muldiv_pkg::op_mul, corner(i), corner(j), 0);
                run_op(muldiv_pkg::op_mulhu, corner(i), corner(j), 0);
            end
        end
        for (int i = 0; i < n_random; i++) begin
            x = random_word();
            y = random_word();
            run_op(muldiv_pkg::op_mul, x, y, 0);
            run_op(muldiv_pkg::op_mulhu, x, y, 0);
        end
        report_test("unsigned multiply", start_errors);

        start_errors = errors;
        for (int i = 0; i < n_corner; i++) begin
            for (int j = 0; j < n_corner; j++) begin
                run_op(muldiv_pkg::op_mulh, corner(i), corner(j), 0);
            end
        end
        for (int i = 0; i < n_random; i++) begin
            run_op(muldiv_pkg::op_mulh, random_word(), random_word(), 0);
        end
        report_test("signed multiply", start_errors);

        start_errors = errors;
        // All four sign combinations of 100 and 7.
        for (int i = 0; i < 4; i++) begin
            x = i[0] ? (~32'd100 + 32'd1) : 32'd100;
            y = i[1] ? (~32'd7 + 32'd1) : 32'd7;
            run_op(muldiv_pkg::op_div, x, y, 0);
            run_op(muldiv_pkg::op_rem, x, y, 0);
        end
        run_op(muldiv_pkg::op_div, 32'h8000_0000, 32'hffff_ffff, 0);
        run_op(muldiv_pkg::op_rem, 32'h8000_0000, 32'hffff_ffff, 0);
        for (int i = 0; i < n_random; i++) begin
            x = random_word();
            y = random_word() >> x[4:0];
            run_op(muldiv_pkg::op_div, x, y, 0);
            run_op(muldiv_pkg::op_rem, x, y, 0);
        end
        report_test("signed divide", start_errors);

        start_errors = errors;
        for (int i = 0; i < n_random; i++) begin
            x = random_word();
            y = (random_word() >> x[4:0]) | 32'h1;
            run_op(muldiv_pkg::op_divu, x, y, 0);
            last_quot = last_result;
            pair_active = 1'b1;
            run_op(muldiv_pkg::op_remu, x, y, 0);
            pair_active = 1'b0;
        end
        report_test("unsigned divide", start_errors);

        start_errors = errors;
        for (int i = 0; i < 3; i++) begin
            x = (i == 0) ? random_word() : corner(i + 2);
            run_op(muldiv_pkg::op_div, x, 32'h0, 0);
            run_op(muldiv_pkg::op_divu, x, 32'h0, 0);
            run_op(muldiv_pkg::op_rem, x, 32'h0, 0);
            run_op(muldiv_pkg::op_remu, x, 32'h0, 0);
        end
        report_test("divide by zero", start_errors);

        start_errors = errors;
        run_op(muldiv_pkg::op_mul, random_word(), random_word(), 6);
        run_op(muldiv_pkg::op_div, random_word(), 32'd3, 12);
        run_op(muldiv_pkg::op_remu, random_word(), 32'h0, 3);
        report_test("handshake", start_errors);

        repeat (2) @(negedge clk);
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
rtl/muldiv_pkg.sv
rtl/restoring_divider.sv
rtl/shift_add_multiplier.sv
rtl/operand_sign_adjust.sv
rtl/muldiv_sequencer.sv
rtl/muldiv_unit.sv
tests/tb_muldiv.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_muldiv
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert --timing --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
